//--- build.f
design/mem_pkg.sv
design/spi_flash_reader.sv
design/boot_loader.sv
design/host_port.sv
design/word_ram.sv
design/memory_top.sv
tests/flash_model.sv
tests/memory_tb.sv

//--- design/boot_loader.sv
`timescale 1ns/1ps

module boot_loader (
  input  logic                             clk,
  input  logic                             reset_in,
  input  logic                             reader_busy,
  input  logic [mem_pkg::BYTE_W-1:0]       rx_byte,
  input  logic                             byte_valid,
  output logic                             read_start,
  output logic [mem_pkg::FLASH_ADDR_W-1:0] read_addr,
  output logic                             load_we,
  output logic [mem_pkg::RAM_ADDR_W-1:0]   load_addr,
  output logic [mem_pkg::WORD_W-1:0]       load_data,
  output logic                             boot_done
);

  localparam int ADDR_PAD_W = mem_pkg::FLASH_ADDR_W - mem_pkg::PAGE_IDX_W - mem_pkg::PAGE_OFS_W;

  logic [1:0]                                     state;
  logic [mem_pkg::PAGE_IDX_W-1:0]                 page_idx;
  logic [mem_pkg::WORD_IDX_W-1:0]                 word_idx;
  logic [mem_pkg::LANE_W-1:0]                     lane;
  logic [mem_pkg::WORD_W-mem_pkg::BYTE_W-1:0]     word_sr;
  logic [mem_pkg::COUNT_W-1:0]                    page_count;
  logic                                           last_page;

  // Page p lives at base + p * 256
  assign read_addr = mem_pkg::FLASH_IMAGE_BASE +
                     {{ADDR_PAD_W{1'b0}}, page_idx, {mem_pkg::PAGE_OFS_W{1'b0}}};

  // Count of zero still loads page 0, RAM capacity caps the loop
  assign last_page = (32'(page_idx) == mem_pkg::MAX_PAGES - 1) ||
                     (32'(page_idx) + 1 >= 32'(page_count));

  assign boot_done = (state == mem_pkg::BL_DONE);

  // -------------------------------------------------------------------
  // Word assembly, first byte lands in the top lane
  // -------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (byte_valid) begin
      word_sr <= {word_sr[mem_pkg::WORD_W-2*mem_pkg::BYTE_W-1:0], rx_byte};
      if (lane == '1) begin
        load_data <= {word_sr, rx_byte};
        load_addr <= {page_idx, word_idx};
      end
    end
  end

  // -------------------------------------------------------------------
  // Page loop
  // -------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      state      <= mem_pkg::BL_ISSUE;
      read_start <= 1'b0;
      load_we    <= 1'b0;
      page_idx   <= '0;
      word_idx   <= '0;
      lane       <= '0;
      page_count <= '0;
    end else begin
      read_start <= 1'b0;
      load_we    <= 1'b0;

      case (state)
        mem_pkg::BL_ISSUE: begin
          read_start <= 1'b1;
          state      <= mem_pkg::BL_WAIT;
        end
        mem_pkg::BL_WAIT: begin
          // Reader raises busy one cycle after the start pulse
          if (reader_busy) begin
            state <= mem_pkg::BL_LOAD;
          end
        end
        mem_pkg::BL_LOAD: begin
          if (byte_valid) begin
            lane <= lane + 1'b1;
            if (lane == '1) begin
              load_we  <= 1'b1;
              word_idx <= word_idx + 1'b1;
              if (page_idx == '0 && word_idx == '0) begin
                page_count <= {word_sr[mem_pkg::BYTE_W-1:0], rx_byte};
              end
            end
          end else if (!reader_busy) begin
            if (last_page) begin
              state <= mem_pkg::BL_DONE;
            end else begin
              page_idx <= page_idx + 1'b1;
              state    <= mem_pkg::BL_ISSUE;
            end
          end
        end
        mem_pkg::BL_DONE: begin
          // Image in RAM, host port owns the array from here on
        end
      endcase
    end
  end

endmodule

//--- design/host_port.sv
`timescale 1ns/1ps

module host_port (
  input  logic                           clk,
  input  logic                           reset_in,
  input  logic                           boot_done,
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [mem_pkg::RAM_ADDR_W-1:0] wb_adr,
  input  logic [mem_pkg::WORD_W-1:0]     wb_dat_w,
  input  logic [mem_pkg::WORD_W-1:0]     rd_data,
  output logic                           wb_ack,
  output logic [mem_pkg::WORD_W-1:0]     wb_dat_r,
  output logic                           host_en,
  output logic                           host_we,
  output logic [mem_pkg::RAM_ADDR_W-1:0] host_addr,
  output logic [mem_pkg::WORD_W-1:0]     host_wdata
);

  logic [1:0] state;
  logic       accept;

  // Requests wait with no ack until boot finishes
  assign accept = boot_done && wb_cyc && wb_stb && (state == mem_pkg::HP_IDLE);

  // RAM output is valid in the ack cycle
  assign wb_dat_r = rd_data;

  always_ff @(posedge clk) begin
    if (accept) begin
      host_addr  <= wb_adr;
      host_wdata <= wb_dat_w;
    end
  end

  // -------------------------------------------------------------------
  // Cycle control
  // -------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      state   <= mem_pkg::HP_IDLE;
      host_en <= 1'b0;
      host_we <= 1'b0;
      wb_ack  <= 1'b0;
    end else begin
      host_en <= 1'b0;
      wb_ack  <= 1'b0;

      case (state)
        mem_pkg::HP_IDLE: begin
          if (accept) begin
            host_en <= 1'b1;
            host_we <= wb_we;
            state   <= mem_pkg::HP_ACCESS;
          end
        end
        mem_pkg::HP_ACCESS: begin
          wb_ack <= 1'b1;
          state  <= mem_pkg::HP_HOLD;
        end
        mem_pkg::HP_HOLD: begin
          // STB is still high in the ack cycle, wait for the master
          if (!wb_stb) begin
            state <= mem_pkg::HP_IDLE;
          end
        end
        default: begin
          state <= mem_pkg::HP_IDLE;
        end
      endcase
    end
  end

endmodule

//--- design/mem_pkg.sv
package mem_pkg;

  // -------------------------------------------------------------------
  // Data and address widths
  // -------------------------------------------------------------------
  localparam int WORD_W     = 32;
  localparam int BYTE_W     = 8;
  localparam int LANE_W     = $clog2(WORD_W / BYTE_W);
  localparam int RAM_ADDR_W = 10;
  localparam int RAM_WORDS  = 1 << RAM_ADDR_W;

  // -------------------------------------------------------------------
  // Image page geometry
  // -------------------------------------------------------------------
  localparam int PAGE_WORDS = 64;
  localparam int PAGE_BYTES = 256;
  localparam int PAGE_IDX_W = 4;
  localparam int WORD_IDX_W = $clog2(PAGE_WORDS);
  localparam int PAGE_OFS_W = $clog2(PAGE_BYTES);
  localparam int MAX_PAGES  = 16;
  localparam int COUNT_W    = 16;

  // -------------------------------------------------------------------
  // SPI flash
  // -------------------------------------------------------------------
  localparam int                      FLASH_ADDR_W     = 24;
  localparam logic [FLASH_ADDR_W-1:0] FLASH_IMAGE_BASE = 24'h080000;
  localparam logic [BYTE_W-1:0]       FLASH_CMD_READ   = 8'h03;

  // Command byte plus three address bytes
  localparam int CMD_BYTES  = 1 + FLASH_ADDR_W / BYTE_W;
  localparam int CMD_W      = CMD_BYTES * BYTE_W;
  localparam int BIT_CNT_W  = $clog2(BYTE_W);
  localparam int BYTE_CNT_W = $clog2(PAGE_BYTES + 1);

  // Divider terminal count, SCK half period is SCK_HALF + 1 clocks
  localparam int SCK_HALF  = 1;
  localparam int SCK_CNT_W = $clog2(SCK_HALF + 1);

  // FSM encodings
  localparam logic [1:0] RD_IDLE = 2'd0;
  localparam logic [1:0] RD_SEND = 2'd1;
  localparam logic [1:0] RD_RECV = 2'd2;
  localparam logic [1:0] RD_DONE = 2'd3;

  localparam logic [1:0] BL_ISSUE = 2'd0;
  localparam logic [1:0] BL_WAIT  = 2'd1;
  localparam logic [1:0] BL_LOAD  = 2'd2;
  localparam logic [1:0] BL_DONE  = 2'd3;

  localparam logic [1:0] HP_IDLE   = 2'd0;
  localparam logic [1:0] HP_ACCESS = 2'd1;
  localparam logic [1:0] HP_HOLD   = 2'd2;

endpackage

//--- design/memory_top.sv
`timescale 1ns/1ps

module memory_top (
  input  logic                           clk,
  input  logic                           reset_in,
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [mem_pkg::RAM_ADDR_W-1:0] wb_adr,
  input  logic [mem_pkg::WORD_W-1:0]     wb_dat_w,
  output logic                           wb_ack,
  output logic [mem_pkg::WORD_W-1:0]     wb_dat_r,
  output logic                           boot_done,
  output logic                           flash_cs_n,
  output logic                           flash_sck,
  output logic                           flash_mosi,
  input  logic                           flash_miso
);

  // Loader and reader
  logic                             read_start;
  logic [mem_pkg::FLASH_ADDR_W-1:0] read_addr;
  logic                             reader_busy;
  logic [mem_pkg::BYTE_W-1:0]       rx_byte;
  logic                             byte_valid;

  // RAM ports
  logic                             load_we;
  logic [mem_pkg::RAM_ADDR_W-1:0]   load_addr;
  logic [mem_pkg::WORD_W-1:0]       load_data;
  logic                             host_en;
  logic                             host_we;
  logic [mem_pkg::RAM_ADDR_W-1:0]   host_addr;
  logic [mem_pkg::WORD_W-1:0]       host_wdata;
  logic [mem_pkg::WORD_W-1:0]       rd_data;

  spi_flash_reader u_reader (
    .clk         (clk),
    .reset_in    (reset_in),
    .read_start  (read_start),
    .read_addr   (read_addr),
    .reader_busy (reader_busy),
    .rx_byte     (rx_byte),
    .byte_valid  (byte_valid),
    .flash_cs_n  (flash_cs_n),
    .flash_sck   (flash_sck),
    .flash_mosi  (flash_mosi),
    .flash_miso  (flash_miso)
  );

  boot_loader u_loader (
    .clk         (clk),
    .reset_in    (reset_in),
    .reader_busy (reader_busy),
    .rx_byte     (rx_byte),
    .byte_valid  (byte_valid),
    .read_start  (read_start),
    .read_addr   (read_addr),
    .load_we     (load_we),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .boot_done   (boot_done)
  );

  host_port u_host (
    .clk        (clk),
    .reset_in   (reset_in),
    .boot_done  (boot_done),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .rd_data    (rd_data),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .host_en    (host_en),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata)
  );

  word_ram u_ram (
    .clk        (clk),
    .load_we    (load_we),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .host_en    (host_en),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .rd_data    (rd_data)
  );

endmodule

//--- design/spi_flash_reader.sv
`timescale 1ns/1ps

module spi_flash_reader (
  input  logic                             clk,
  input  logic                             reset_in,
  input  logic                             read_start,
  input  logic [mem_pkg::FLASH_ADDR_W-1:0] read_addr,
  output logic                             reader_busy,
  output logic [mem_pkg::BYTE_W-1:0]       rx_byte,
  output logic                             byte_valid,
  output logic                             flash_cs_n,
  output logic                             flash_sck,
  output logic                             flash_mosi,
  input  logic                             flash_miso
);

  logic [1:0]                     state;
  logic [mem_pkg::SCK_CNT_W-1:0]  div_cnt;
  logic                           sck_tick;
  logic                           sck_rise;
  logic                           sck_fall;
  logic                           last_bit;
  logic [mem_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic [mem_pkg::BYTE_CNT_W-1:0] byte_cnt;
  logic [mem_pkg::CMD_W-1:0]      tx_shift;
  logic [mem_pkg::BYTE_W-1:0]     rx_shift;

  assign reader_busy = (state != mem_pkg::RD_IDLE);
  assign sck_tick    = reader_busy && (32'(div_cnt) == mem_pkg::SCK_HALF);
  assign sck_rise    = sck_tick && !flash_sck;
  assign sck_fall    = sck_tick && flash_sck;
  assign last_bit    = (32'(bit_cnt) == mem_pkg::BYTE_W - 1);

  // MSB first on both lines
  assign flash_mosi = tx_shift[mem_pkg::CMD_W-1];
  assign rx_byte    = rx_shift;

  // -------------------------------------------------------------------
  // SCK divider, free running only inside a transaction
  // -------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      div_cnt <= '0;
    end else if (sck_tick || !reader_busy) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Receive shifter, sampled on rising SCK (mode 0)
  always_ff @(posedge clk) begin
    if (sck_rise && state == mem_pkg::RD_RECV) begin
      rx_shift <= {rx_shift[mem_pkg::BYTE_W-2:0], flash_miso};
    end
  end

  // -------------------------------------------------------------------
  // Transaction FSM
  // -------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      state      <= mem_pkg::RD_IDLE;
      flash_cs_n <= 1'b1;
      flash_sck  <= 1'b0;
      byte_valid <= 1'b0;
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      tx_shift   <= '0;
    end else begin
      byte_valid <= 1'b0;

      // MOSI moves on falling SCK, zeros follow the address
      if (sck_fall) begin
        tx_shift <= {tx_shift[mem_pkg::CMD_W-2:0], 1'b0};
      end

      case (state)
        mem_pkg::RD_IDLE: begin
          if (read_start) begin
            tx_shift   <= {mem_pkg::FLASH_CMD_READ, read_addr};
            flash_cs_n <= 1'b0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            state      <= mem_pkg::RD_SEND;
          end
        end
        mem_pkg::RD_SEND: begin
          if (sck_tick) begin
            flash_sck <= !flash_sck;
          end
          if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
              byte_cnt <= byte_cnt + 1'b1;
              // Header out, flash starts driving data next falling edge
              if (32'(byte_cnt) == mem_pkg::CMD_BYTES - 1) begin
                byte_cnt <= '0;
                state    <= mem_pkg::RD_RECV;
              end
            end
          end
        end
        mem_pkg::RD_RECV: begin
          if (sck_tick) begin
            flash_sck <= !flash_sck;
          end
          if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
              byte_valid <= 1'b1;
              byte_cnt   <= byte_cnt + 1'b1;
              if (32'(byte_cnt) == mem_pkg::PAGE_BYTES - 1) begin
                state <= mem_pkg::RD_DONE;
              end
            end
          end
        end
        mem_pkg::RD_DONE: begin
          // Finish the last SCK high phase, then release CS
          if (sck_fall) begin
            flash_sck <= 1'b0;
          end else if (sck_rise) begin
            flash_cs_n <= 1'b1;
            state      <= mem_pkg::RD_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- design/word_ram.sv
`timescale 1ns/1ps

module word_ram (
  input  logic                           clk,
  input  logic                           load_we,
  input  logic [mem_pkg::RAM_ADDR_W-1:0] load_addr,
  input  logic [mem_pkg::WORD_W-1:0]     load_data,
  input  logic                           host_en,
  input  logic                           host_we,
  input  logic [mem_pkg::RAM_ADDR_W-1:0] host_addr,
  input  logic [mem_pkg::WORD_W-1:0]     host_wdata,
  output logic [mem_pkg::WORD_W-1:0]     rd_data
);

  logic [mem_pkg::WORD_W-1:0]     mem [mem_pkg::RAM_WORDS];
  logic                           port_we;
  logic                           port_rd;
  logic [mem_pkg::RAM_ADDR_W-1:0] port_addr;
  logic [mem_pkg::WORD_W-1:0]     port_wdata;

  // Single port, the loader wins
  assign port_we    = load_we || (host_en && host_we);
  assign port_rd    = !load_we && host_en && !host_we;
  assign port_addr  = load_we ? load_addr : host_addr;
  assign port_wdata = load_we ? load_data : host_wdata;

  always_ff @(posedge clk) begin
    if (port_we) begin
      mem[port_addr] <= port_wdata;
    end
    if (port_rd) begin
      rd_data <= mem[port_addr];
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build memory_tb with Verilator, run it, and judge the result from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module memory_tb \
  -f build.f -o memory_sim > sim.log 2>&1 \
  && ./obj_dir/memory_sim >> sim.log 2>&1 \
  || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- tests/flash_model.sv
`timescale 1ns/1ps

module flash_model (
  input  logic cs_n,
  input  logic sck,
  input  logic mosi,
  output logic miso
);

  localparam int HDR_BITS  = mem_pkg::CMD_W;
  localparam int DATA_BITS = mem_pkg::PAGE_BYTES * mem_pkg::BYTE_W;
  localparam int IMG_BYTES = mem_pkg::RAM_WORDS * 4;

  typedef logic [mem_pkg::RAM_ADDR_W-1:0] addr_t;

  // Image words, sent most significant byte first
  logic [mem_pkg::WORD_W-1:0] image [mem_pkg::RAM_WORDS];
  logic [HDR_BITS-1:0]        header;
  logic [mem_pkg::BYTE_W-1:0] cur_byte;
  logic                       in_trans;
  int                         rise_cnt;
  int                         data_bit;
  int                         page_ofs;
  int                         trans_count;
  int                         error_count;

  initial begin
    miso        = 1'b0;
    in_trans    = 1'b0;
    rise_cnt    = 0;
    page_ofs    = 0;
    trans_count = 0;
    error_count = 0;
  end

  function automatic logic [7:0] image_byte(input int ofs);
    logic [mem_pkg::WORD_W-1:0] word;
    if (ofs < 0 || ofs >= IMG_BYTES) begin
      return 8'h00;
    end
    word = image[addr_t'(ofs / 4)] << (8 * (ofs % 4));
    return word[mem_pkg::WORD_W-1 -: 8];
  endfunction

  // -------------------------------------------------------------------
  // Command and address check
  // -------------------------------------------------------------------
  task automatic check_header();
    int exp_addr;
    int got_addr;
    exp_addr = int'(mem_pkg::FLASH_IMAGE_BASE) + trans_count * mem_pkg::PAGE_BYTES;
    got_addr = int'(header[mem_pkg::FLASH_ADDR_W-1:0]);
    if (header[HDR_BITS-1 -: mem_pkg::BYTE_W] != mem_pkg::FLASH_CMD_READ) begin
      $display("Flash transaction %0d sent command 0x%h instead of the READ command",
               trans_count, header[HDR_BITS-1 -: mem_pkg::BYTE_W]);
      error_count++;
    end
    if (got_addr != exp_addr) begin
      $display("Flash transaction %0d asked for address 0x%h, expected 0x%h",
               trans_count, got_addr, exp_addr);
      error_count++;
    end
    page_ofs    = got_addr - int'(mem_pkg::FLASH_IMAGE_BASE);
    trans_count = trans_count + 1;
  endtask

  always @(negedge cs_n) begin
    in_trans = 1'b1;
    rise_cnt = 0;
  end

  always @(posedge cs_n) begin
    if (in_trans && rise_cnt != HDR_BITS + DATA_BITS) begin
      $display("Flash transaction ended after %0d SCK cycles instead of %0d",
               rise_cnt, HDR_BITS + DATA_BITS);
      error_count++;
    end
    in_trans = 1'b0;
  end

  // Mode 0, MOSI sampled on rising SCK
  always @(posedge sck) begin
    if (in_trans) begin
      if (rise_cnt < HDR_BITS) begin
        header = {header[HDR_BITS-2:0], mosi};
      end
      rise_cnt = rise_cnt + 1;
      if (rise_cnt == HDR_BITS) begin
        check_header();
      end
    end
  end

  // MISO changes on falling SCK once the header is in
  always @(negedge sck) begin
    if (in_trans && rise_cnt >= HDR_BITS) begin
      data_bit = rise_cnt - HDR_BITS;
      cur_byte = image_byte(page_ofs + data_bit / 8) << (data_bit % 8);
      miso     = cur_byte[mem_pkg::BYTE_W-1];
    end
  end

endmodule

//--- tests/memory_tb.sv
`timescale 1ns/1ps

module memory_tb;

  localparam int CLK_PERIOD  = 10;
  localparam int SEED        = 50;
  localparam int IMAGE_PAGES = 3;
  localparam int IMAGE_WORDS = IMAGE_PAGES * mem_pkg::PAGE_WORDS;
  localparam int N_READS     = 40;
  localparam int N_WRITES    = 24;

  // Roughly 260 bytes per page at 32 clocks per byte
  localparam int BOOT_CYCLES     = IMAGE_PAGES * 260 * 32;
  localparam int HOST_CYCLES     = (1 + N_READS + 2 * N_WRITES) * 8;
  localparam int WATCHDOG_CYCLES = 2 * BOOT_CYCLES + HOST_CYCLES;
  localparam int ACK_LIMIT       = 2 * BOOT_CYCLES;

  typedef logic [mem_pkg::RAM_ADDR_W-1:0] addr_t;
  typedef logic [mem_pkg::WORD_W-1:0]     word_t;

  logic  clk;
  logic  reset_in;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  addr_t wb_adr;
  word_t wb_dat_w;
  logic  wb_ack;
  word_t wb_dat_r;
  logic  boot_done;
  logic  flash_cs_n;
  logic  flash_sck;
  logic  flash_mosi;
  logic  flash_miso;

  word_t image_words [mem_pkg::RAM_WORDS];
  word_t shadow [mem_pkg::RAM_WORDS];
  logic  written [mem_pkg::RAM_WORDS];
  addr_t wr_addrs [$];
  word_t rng_state;
  addr_t wr_adr;
  int    idx;
  int    seq_errors;

  // Compare process state
  int    bus_errors;
  int    cycle_cnt;
  int    accept_cycle;
  int    clr_idx;
  logic  busy;
  logic  acc_we;
  addr_t acc_adr;
  word_t exp_data;

  memory_top u_memory_top (
    .clk        (clk),
    .reset_in   (reset_in),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .boot_done  (boot_done),
    .flash_cs_n (flash_cs_n),
    .flash_sck  (flash_sck),
    .flash_mosi (flash_mosi),
    .flash_miso (flash_miso)
  );

  flash_model u_flash (
    .cs_n (flash_cs_n),
    .sck  (flash_sck),
    .mosi (flash_mosi),
    .miso (flash_miso)
  );

  always begin
    #(CLK_PERIOD / 2);
    clk = !clk;
  end

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Image words first, host writes override them
  function automatic word_t expected_word(input addr_t addr);
    if (written[addr]) begin
      return shadow[addr];
    end else if (32'(addr) < IMAGE_WORDS) begin
      return image_words[addr];
    end
    return 'x;
  endfunction

  task automatic build_image();
    int n;
    for (n = 0; n < IMAGE_WORDS; n++) begin
      rng_state = lcg_next(rng_state);
      image_words[addr_t'(n)] = rng_state;
    end
    // Page count lives in the low half of word 0
    image_words[0][15:0] = 16'(IMAGE_PAGES);
    for (n = 0; n < IMAGE_WORDS; n++) begin
      u_flash.image[addr_t'(n)] = image_words[addr_t'(n)];
    end
  endtask

  // -------------------------------------------------------------------
  // Wishbone master, one classic cycle per call
  // -------------------------------------------------------------------
  task automatic bus_access(input logic we, input addr_t adr, input word_t dat);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    @(negedge clk);
    while (!wb_ack && waited < ACK_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!wb_ack) begin
      $display("No wb_ack for the access at address %0d after %0d cycles", adr, waited);
      seq_errors++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // -------------------------------------------------------------------
  // Compare process, acks checked at the edge the master sees them
  // -------------------------------------------------------------------
  always @(posedge clk) begin
    if (reset_in) begin
      busy       = 1'b0;
      cycle_cnt  = 0;
      bus_errors = 0;
      for (clr_idx = 0; clr_idx < mem_pkg::RAM_WORDS; clr_idx++) begin
        written[addr_t'(clr_idx)] = 1'b0;
      end
    end else begin
      cycle_cnt = cycle_cnt + 1;
      if (wb_ack) begin
        if (!busy) begin
          $display("wb_ack came at %0t with no accepted request", $time);
          bus_errors++;
        end else begin
          if (cycle_cnt != accept_cycle + 2) begin
            $display("Error at %0t: wb_ack after %0d edges, expected 2",
                     $time, cycle_cnt - accept_cycle);
            bus_errors++;
          end
          if (!acc_we && wb_dat_r !== exp_data) begin
            $display("Error at %0t: wb_dat_r = 0x%h, expected 0x%h (address %0d)",
                     $time, wb_dat_r, exp_data, acc_adr);
            bus_errors++;
          end
          busy = 1'b0;
        end
      end else if (busy && cycle_cnt > accept_cycle + 2) begin
        $display("No wb_ack two edges after the request at address %0d", acc_adr);
        bus_errors++;
        busy = 1'b0;
      end
      // STB is still up in the ack cycle and is not a new request
      if (wb_cyc && wb_stb && boot_done && !busy && !wb_ack) begin
        accept_cycle = cycle_cnt;
        acc_we       = wb_we;
        acc_adr      = wb_adr;
        busy         = 1'b1;
        if (wb_we) begin
          shadow[wb_adr]  = wb_dat_w;
          written[wb_adr] = 1'b1;
        end else begin
          exp_data = expected_word(wb_adr);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    reset_in   = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    seq_errors = 0;
    rng_state  = word_t'(SEED);
    build_image();

    repeat (3) @(negedge clk);
    reset_in = 1'b0;

    // Boot has just started, so this read has to stall
    if (boot_done) begin
      $display("boot_done was already high right after reset");
      seq_errors++;
    end
    bus_access(1'b0, '0, '0);

    // Random reads inside the loaded image
    for (idx = 0; idx < N_READS; idx++) begin
      rng_state = lcg_next(rng_state);
      bus_access(1'b0, addr_t'((rng_state >> 8) % IMAGE_WORDS), '0);
    end

    // Writes, every other one above the image, then read back
    for (idx = 0; idx < N_WRITES; idx++) begin
      rng_state = lcg_next(rng_state);
      if (idx % 2 == 0) begin
        wr_adr = addr_t'(IMAGE_WORDS + (rng_state >> 8) % (mem_pkg::RAM_WORDS - IMAGE_WORDS));
      end else begin
        wr_adr = addr_t'((rng_state >> 8) % mem_pkg::RAM_WORDS);
      end
      rng_state = lcg_next(rng_state);
      wr_addrs.push_back(wr_adr);
      bus_access(1'b1, wr_adr, rng_state);
    end
    while (wr_addrs.size() > 0) begin
      wr_adr = wr_addrs.pop_front();
      bus_access(1'b0, wr_adr, '0);
    end

    if (u_flash.trans_count != IMAGE_PAGES) begin
      $display("Flash saw %0d transactions, expected %0d", u_flash.trans_count, IMAGE_PAGES);
      seq_errors++;
    end
    repeat (2) @(negedge clk);

    $display("Errors: bus %0d, sequence %0d, flash %0d",
             bus_errors, seq_errors, u_flash.error_count);
    if (bus_errors + seq_errors + u_flash.error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
